/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_udp_config_responder
FILELIST  ?= udp_config_responder.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/tb_spi_flash_model.sv */
module tb_spi_flash_model (
    input  logic spi_sck,
    input  logic spi_cs,
    input  logic spi_mosi,
    output logic spi_miso
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0] image [0:63];
    logic [31:0] cmd;
    int          bit_cnt;
    int          byte_idx;

    initial
    begin
        $readmemh("bench/udp_config_responder_testdata.txt", image);
        spi_miso = 1'b0;
        bit_cnt  = 0;
        cmd      = '0;
    end

    always @(posedge spi_cs)
    begin
        bit_cnt = 0;
    end

    // Command and address come in on rising SCK
    always @(posedge spi_sck)
    begin
        if (!spi_cs)
        begin
            if (bit_cnt < 32)
                cmd = {cmd[30:0], spi_mosi};
            bit_cnt = bit_cnt + 1;
        end
    end

    // Data goes out on falling SCK, MSB first
    always @(negedge spi_sck)
    begin
        if (!spi_cs && bit_cnt >= 32)
        begin
            byte_idx = int'(cmd[23:0]) + (bit_cnt - 32) / 8;
            if (cmd[31:24] == 8'h03 && byte_idx < 26)
                spi_miso <= image[byte_idx][7 - ((bit_cnt - 32) % 8)];
            else
                spi_miso <= 1'b1;
        end
    end

endmodule

/* bench/tb_udp_config_responder.sv */
`include "responder_settings.svh"

module tb_udp_config_responder;

    timeunit 1ns;
    timeprecision 100ps;

    import responder_pkg::*;

    logic clk;
    logic rst;
    logic spi_sck, spi_mosi, spi_miso, spi_cs, cfg_valid;
    logic rx_hdr_valid, rx_hdr_ready;
    udp_port_t rx_dst_port, rx_src_port;
    logic [31:0] rx_src_ip;
    logic [15:0] rx_length;
    logic rx_payload_valid, rx_payload_ready, rx_payload_last, rx_payload_user;
    logic tx_hdr_valid, tx_hdr_ready;
    udp_port_t tx_src_port, tx_dst_port;
    logic [31:0] tx_src_ip, tx_dst_ip;
    logic [15:0] tx_length;
    logic [7:0] tx_ttl;
    logic [7:0] rd_data;
    logic rd_valid, rd_last, rd_user, rd_ready;

    logic [31:0]  td [0:63];
    logic [7:0]   exp_table [16];
    demo_idx_t    exp_ptr;
    logic [119:0] hdr_q [$];
    logic [9:0]   byte_q [$];
    int           test_errs [1:6];
    logic         random_ready;
    logic         hold_rd;
    int           limit_cycles;

    udp_config_responder u_udp_config_responder (.*);

    tb_spi_flash_model u_flash (
        .spi_sck  (spi_sck),
        .spi_cs   (spi_cs),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso)
    );

    always #4 clk = ~clk;

    always @(negedge clk)
    begin
        if (random_ready)
        begin
            tx_hdr_ready <= 1'($urandom % 2);
            rd_ready     <= !hold_rd && (($urandom % 4) != 0);
        end
    end

    // Record every header and byte that leaves the DUT
    always @(posedge clk)
    begin
        if (!rst && tx_hdr_valid && tx_hdr_ready)
            hdr_q.push_back({tx_src_port, tx_dst_port, tx_src_ip, tx_dst_ip, tx_length, tx_ttl});
        if (!rst && rd_valid && rd_ready)
            byte_q.push_back({rd_user, rd_last, rd_data});
    end

    initial
    begin
        wait (limit_cycles != 0);
        #(limit_cycles * 8);
        $display("Timeout after %0d cycles, DUT stopped responding", limit_cycles);
        $display("test failed");
        $finish;
    end

    task automatic check_value(input int id, input string name,
                               input logic [31:0] got, input logic [31:0] exp);
        logic same;
        same = (got === exp);
        if (!same)
            test_errs[id]++;
        assert (same)
        else
            $display("FAILED %0t %s got %h expected %h", $time, name, got, exp);
    endtask

    task automatic report_test(input int id, input string name);
        $display("Test %0d %s: %s", id, name, (test_errs[id] == 0) ? "ok" : "errors");
    endtask

    // Octets from low/high nibble pairs, most significant first
    function automatic logic [31:0] assemble_word(input int base);
        logic [31:0] w;
        w = '0;
        for (int k = 0; k < 4; k++)
            w = {w[23:0], td[base + 2 * k + 1][3:0], td[base + 2 * k][3:0]};
        return w;
    endfunction

    task automatic drive_frame(input int f);
        int nbytes;
        nbytes = int'(td[27 + 6 * f + 4]);
        @(negedge clk);
        rx_dst_port  = td[27 + 6 * f][15:0];
        rx_src_port  = td[27 + 6 * f + 1][15:0];
        rx_src_ip    = td[27 + 6 * f + 2];
        rx_length    = td[27 + 6 * f + 3][15:0];
        rx_hdr_valid = 1'b1;
        do @(posedge clk); while (!rx_hdr_ready);
        @(negedge clk);
        rx_hdr_valid = 1'b0;
        for (int i = 0; i < nbytes; i++)
        begin
            rx_payload_valid = 1'b1;
            rx_payload_last  = (i == nbytes - 1);
            rx_payload_user  = (i == nbytes - 1) && td[27 + 6 * f + 5][0];
            do @(posedge clk); while (!rx_payload_ready);
            @(negedge clk);
        end
        rx_payload_valid = 1'b0;
        rx_payload_last  = 1'b0;
        rx_payload_user  = 1'b0;
    endtask

    // Bytes taken before a full FIFO pushes back on the input
    task automatic count_until_stall();
        int taken;
        taken = 0;
        do
        begin
            @(posedge clk);
            if (rx_payload_valid && rx_payload_ready)
                taken++;
        end
        while (!(rx_payload_valid && !rx_payload_ready));
        check_value(6, "bytes before stall", 32'(taken), 32'(`PAYLOAD_FIFO_DEPTH));
        hold_rd = 1'b0;
    endtask

    task automatic check_reply(input int f, input int hdr_id, input int pay_id);
        logic [119:0] h;
        logic [9:0]   b;
        int           nbytes;
        nbytes = int'(td[27 + 6 * f + 4]);
        while (hdr_q.size() < 1 || byte_q.size() < nbytes)
            @(posedge clk);
        h = hdr_q.pop_front();
        check_value(f == 0 ? 2 : hdr_id, "tx_src_ip", h[87:56], assemble_word(2));
        check_value(hdr_id, "tx_src_port", 32'(h[119:104]), 32'(td[27 + 6 * f][15:0]));
        check_value(hdr_id, "tx_dst_port", 32'(h[103:88]), 32'(td[27 + 6 * f + 1][15:0]));
        check_value(hdr_id, "tx_dst_ip", h[55:24], td[27 + 6 * f + 2]);
        check_value(hdr_id, "tx_length", 32'(h[23:8]), 32'(td[27 + 6 * f + 3][15:0]));
        check_value(hdr_id, "tx_ttl", 32'(h[7:0]), 32'd64);
        for (int i = 0; i < nbytes; i++)
        begin
            b = byte_q.pop_front();
            check_value(pay_id, "rd_data", 32'(b[7:0]), 32'(exp_table[exp_ptr]));
            check_value(pay_id, "rd_last", 32'(b[8]), 32'(i == nbytes - 1));
            check_value(pay_id, "rd_user",
                        32'(b[9]), 32'((i == nbytes - 1) && td[27 + 6 * f + 5][0]));
            exp_ptr = exp_ptr + 1'b1;
        end
    endtask

    initial
    begin
        int total_bytes;
        int total_errs;
        logic after_drop;
        logic [31:0] ip_word;
        logic [31:0] gw_word;
        logic [31:0] mask_word;
        void'($urandom(32'h2b4f07c5));
        $readmemh("bench/udp_config_responder_testdata.txt", td);
        clk = 0;
        rst = 1;
        rx_hdr_valid = 0;
        rx_dst_port = '0;
        rx_src_port = '0;
        rx_src_ip = '0;
        rx_length = '0;
        rx_payload_valid = 0;
        rx_payload_last = 0;
        rx_payload_user = 0;
        tx_hdr_ready = 0;
        rd_ready = 0;
        random_ready = 0;
        hold_rd = 0;
        exp_ptr = '0;
        after_drop = 0;
        for (int t = 1; t <= 6; t++)
            test_errs[t] = 0;

        total_bytes = 0;
        for (int f = 0; f < int'(td[26]); f++)
            total_bytes += int'(td[27 + 6 * f + 4]);
        limit_cycles = (32 + 8 * `CFG_BYTE_COUNT) * 2 * `SPI_CLK_DIV + 200
                       + 200 * total_bytes;

        // Expected demo table from the flash image
        ip_word   = assemble_word(2);
        gw_word   = assemble_word(10);
        mask_word = assemble_word(18);
        for (int k = 0; k < 4; k++)
        begin
            exp_table[k]     = ip_word[31 - 8 * k -: 8];
            exp_table[4 + k] = gw_word[31 - 8 * k -: 8];
            exp_table[8 + k] = mask_word[31 - 8 * k -: 8];
        end
        exp_table[12] = 8'h11;
        exp_table[13] = 8'h22;
        exp_table[14] = 8'h33;
        exp_table[15] = 8'h44;

        repeat (16) @(negedge clk);
        check_value(1, "tx_hdr_valid", 32'(tx_hdr_valid), 32'd0);
        check_value(1, "rd_valid", 32'(rd_valid), 32'd0);
        check_value(1, "cfg_valid", 32'(cfg_valid), 32'd0);
        check_value(1, "spi_cs", 32'(spi_cs), 32'd1);
        rst = 0;
        random_ready = 1;
        report_test(1, "reset state");

        while (!cfg_valid)
            @(posedge clk);

        for (int f = 0; f < int'(td[26]); f++)
        begin
            if (int'(td[27 + 6 * f + 4]) > `PAYLOAD_FIFO_DEPTH
                && td[27 + 6 * f][15:0] == `RESPONDER_PORT)
            begin
                // Output held back until the full FIFO stalls the input
                hold_rd = 1'b1;
                fork
                    drive_frame(f);
                    count_until_stall();
                join
            end
            else
            begin
                drive_frame(f);
            end
            if (td[27 + 6 * f][15:0] != `RESPONDER_PORT)
            begin
                repeat (20) @(posedge clk);
                check_value(5, "tx header count", 32'(hdr_q.size()), 32'd0);
                check_value(5, "rd byte count", 32'(byte_q.size()), 32'd0);
                after_drop = 1;
            end
            else
            begin
                if (after_drop)
                    check_reply(f, 3, 5);
                else if (int'(td[27 + 6 * f + 4]) > `PAYLOAD_FIFO_DEPTH)
                    check_reply(f, 3, 6);
                else
                    check_reply(f, 3, 4);
                if (f == 0)
                    report_test(2, "config load and source IP");
                if (after_drop)
                    report_test(5, "dropped frame");
                after_drop = 0;
            end
        end
        report_test(3, "reply header");
        report_test(4, "demo payload");
        report_test(6, "long run under back-pressure");

        total_errs = 0;
        for (int t = 1; t <= 6; t++)
            total_errs += test_errs[t];
        $display("Tests run 6, mismatches %0d", total_errs);
        if (total_errs == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

/* bench/udp_config_responder_testdata.txt */
// Words 0..25: flash bytes (two skipped, then low/high nibble pairs per octet)
// Word 26: frame count; then per frame: dst_port src_port src_ip length nbytes tuser
ff ee
30 4c 78 6a 91 20 fa 50
00 0c 08 0a 01 00 01 00
0f 0f 0f 0f 0f 0f 00 00
4
// Matching frame, five bytes
04d2 c350 c0a8010b 000d 5 0
// Other port, dropped
0050 1f90 c0a80164 000f 7 0
// Matching frame after the drop, tuser on the last byte
04d2 d431 0a000002 000b 3 1
// Long frame, more than the FIFO holds
04d2 ea60 c0a80102 004e 46 0

/* common/byte_stream_if.sv */
interface byte_stream_if;

    logic [7:0] tdata;
    logic       tvalid;
    logic       tready;
    logic       tlast;
    logic       tuser;

    modport source (
        output tdata, tvalid, tlast, tuser,
        input  tready
    );

    modport sink (
        input  tdata, tvalid, tlast, tuser,
        output tready
    );

endinterface

/* common/responder_pkg.sv */
package responder_pkg;

    // One address word, seen whole or as octets
    typedef union packed {
        logic [31:0]     word;
        // Most significant octet at index 0
        logic [0:3][7:0] octets;
    } ipv4_addr_u;

    typedef logic [15:0] udp_port_t;

    // Index into the 16-entry demo payload table
    typedef logic [3:0] demo_idx_t;

    // Demo table, entry 0 in the leftmost byte
    typedef logic [0:15][7:0] demo_table_t;

endpackage

/* common/responder_settings.svh */
`ifndef RESPONDER_SETTINGS_SVH
`define RESPONDER_SETTINGS_SVH

// UDP port that gets a reply
`define RESPONDER_PORT 16'd1234
`define REPLY_TTL 8'd64

// Flash configuration block
`define FLASH_CFG_ADDR 24'h000000
`define CFG_SKIP_BYTES 2
`define CFG_BYTE_COUNT 26

// clk cycles per SCK half period
`define SPI_CLK_DIV 4

`define PAYLOAD_FIFO_DEPTH 64

`endif

/* flash_config/ip_config_loader.sv */
`include "responder_settings.svh"

module ip_config_loader (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [7:0]               cfg_byte,
    input  logic                     cfg_byte_strobe,
    output logic                     cfg_done,
    output responder_pkg::ipv4_addr_u local_ip,
    output responder_pkg::ipv4_addr_u gateway_ip,
    output responder_pkg::ipv4_addr_u subnet_mask
);

    import responder_pkg::*;

    logic [4:0] byte_cnt;
    logic [4:0] cfg_idx;

    // Low nibble first, octets from the top of the word
    function automatic ipv4_addr_u put_nibble(
        input ipv4_addr_u cur,
        input logic [2:0] pos,
        input logic [3:0] nib
    );
        ipv4_addr_u upd;
        upd = cur;
        if (pos[0])
            upd.octets[pos[2:1]][7:4] = nib;
        else
            upd.octets[pos[2:1]][3:0] = nib;
        return upd;
    endfunction

    assign cfg_done = (byte_cnt == 5'(`CFG_BYTE_COUNT));
    assign cfg_idx  = byte_cnt - 5'(`CFG_SKIP_BYTES);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            byte_cnt    <= '0;
            local_ip    <= '0;
            gateway_ip  <= '0;
            subnet_mask <= '0;
        end
        else if (cfg_byte_strobe && !cfg_done)
        begin
            byte_cnt <= byte_cnt + 1'b1;
            if (byte_cnt >= 5'(`CFG_SKIP_BYTES))
            begin
                // Eight nibbles per word
                case (cfg_idx[4:3])
                    2'd0:    local_ip    <= put_nibble(local_ip, cfg_idx[2:0], cfg_byte[3:0]);
                    2'd1:    gateway_ip  <= put_nibble(gateway_ip, cfg_idx[2:0], cfg_byte[3:0]);
                    default: subnet_mask <= put_nibble(subnet_mask, cfg_idx[2:0], cfg_byte[3:0]);
                endcase
            end
        end
    end

endmodule

/* flash_config/spi_flash_reader.sv */
`include "responder_settings.svh"

module spi_flash_reader (
    input  logic       clk,
    input  logic       rst,
    output logic       spi_sck,
    output logic       spi_mosi,
    input  logic       spi_miso,
    output logic       spi_cs,
    input  logic       cfg_done,
    output logic [7:0] cfg_byte,
    output logic       cfg_byte_strobe
);

    localparam int DIV_W = $clog2(`SPI_CLK_DIV);

    typedef enum logic [1:0] {ST_START, ST_CMD, ST_READ, ST_DONE} state_t;

    state_t             state;
    logic [DIV_W-1:0]   div_cnt;
    logic [4:0]         bit_cnt;
    logic [31:0]        tx_shift;
    logic [6:0]         rx_shift;
    logic               tick;

    assign tick = (div_cnt == DIV_W'(`SPI_CLK_DIV - 1));
    assign spi_mosi = tx_shift[31];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state           <= ST_START;
            spi_cs          <= 1'b1;
            spi_sck         <= 1'b0;
            div_cnt         <= '0;
            bit_cnt         <= '0;
            tx_shift        <= '0;
            cfg_byte_strobe <= 1'b0;
        end
        else
        begin
            cfg_byte_strobe <= 1'b0;
            case (state)
                ST_START:
                begin
                    // Read command, then 24-bit address
                    spi_cs   <= 1'b0;
                    tx_shift <= {8'h03, `FLASH_CFG_ADDR};
                    div_cnt  <= '0;
                    bit_cnt  <= '0;
                    state    <= ST_CMD;
                end
                ST_CMD, ST_READ:
                begin
                    if (cfg_done)
                    begin
                        spi_cs  <= 1'b1;
                        spi_sck <= 1'b0;
                        state   <= ST_DONE;
                    end
                    else
                    begin
                        div_cnt <= tick ? '0 : div_cnt + 1'b1;
                        if (tick)
                        begin
                            spi_sck <= ~spi_sck;
                            if (!spi_sck && state == ST_READ)
                            begin
                                // Rising edge, sample MISO
                                rx_shift <= {rx_shift[5:0], spi_miso};
                                if (bit_cnt == 5'd7)
                                begin
                                    cfg_byte        <= {rx_shift, spi_miso};
                                    cfg_byte_strobe <= 1'b1;
                                    bit_cnt         <= '0;
                                end
                                else
                                begin
                                    bit_cnt <= bit_cnt + 1'b1;
                                end
                            end
                            else if (spi_sck && state == ST_CMD)
                            begin
                                // Falling edge, next command bit
                                tx_shift <= tx_shift << 1;
                                if (bit_cnt == 5'd31)
                                begin
                                    bit_cnt <= '0;
                                    state   <= ST_READ;
                                end
                                else
                                begin
                                    bit_cnt <= bit_cnt + 1'b1;
                                end
                            end
                        end
                    end
                end
                default:
                begin
                    spi_cs <= 1'b1;
                end
            endcase
        end
    end

endmodule

/* source/payload_fifo.sv */
`include "responder_settings.svh"

module payload_fifo (
    input  logic       clk,
    input  logic       rst,
    byte_stream_if.sink wr,
    output logic [7:0] rd_data,
    output logic       rd_valid,
    output logic       rd_last,
    output logic       rd_user,
    input  logic       rd_ready
);

    localparam int DEPTH = `PAYLOAD_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    // Entry is {tuser, tlast, tdata}
    logic [9:0]  mem [DEPTH];
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        full;
    logic        empty;

    // Extra pointer bit tells full from empty
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign wr.tready = !full;
    assign rd_valid  = !empty;
    assign {rd_user, rd_last, rd_data} = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk)
    begin
        if (wr.tvalid && !full)
            mem[wr_ptr[AW-1:0]] <= {wr.tuser, wr.tlast, wr.tdata};
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (wr.tvalid && !full)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_ready && !empty)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

/* source/udp_config_responder.sv */
module udp_config_responder (
    input  logic                     clk,
    input  logic                     rst,

    output logic                     spi_sck,
    output logic                     spi_mosi,
    input  logic                     spi_miso,
    output logic                     spi_cs,
    output logic                     cfg_valid,

    input  logic                     rx_hdr_valid,
    output logic                     rx_hdr_ready,
    input  responder_pkg::udp_port_t rx_dst_port,
    input  responder_pkg::udp_port_t rx_src_port,
    input  logic [31:0]              rx_src_ip,
    input  logic [15:0]              rx_length,
    input  logic                     rx_payload_valid,
    output logic                     rx_payload_ready,
    input  logic                     rx_payload_last,
    input  logic                     rx_payload_user,

    output logic                     tx_hdr_valid,
    input  logic                     tx_hdr_ready,
    output responder_pkg::udp_port_t tx_src_port,
    output responder_pkg::udp_port_t tx_dst_port,
    output logic [31:0]              tx_src_ip,
    output logic [31:0]              tx_dst_ip,
    output logic [15:0]              tx_length,
    output logic [7:0]               tx_ttl,

    output logic [7:0]               rd_data,
    output logic                     rd_valid,
    output logic                     rd_last,
    output logic                     rd_user,
    input  logic                     rd_ready
);

    import responder_pkg::*;

    logic [7:0] cfg_byte;
    logic       cfg_byte_strobe;
    logic       cfg_done;
    ipv4_addr_u local_ip;
    ipv4_addr_u gateway_ip;
    ipv4_addr_u subnet_mask;

    byte_stream_if reply_stream ();

    assign cfg_valid = cfg_done;

    spi_flash_reader u_spi_flash_reader (
        .clk             (clk),
        .rst             (rst),
        .spi_sck         (spi_sck),
        .spi_mosi        (spi_mosi),
        .spi_miso        (spi_miso),
        .spi_cs          (spi_cs),
        .cfg_done        (cfg_done),
        .cfg_byte        (cfg_byte),
        .cfg_byte_strobe (cfg_byte_strobe)
    );

    ip_config_loader u_ip_config_loader (
        .clk             (clk),
        .rst             (rst),
        .cfg_byte        (cfg_byte),
        .cfg_byte_strobe (cfg_byte_strobe),
        .cfg_done        (cfg_done),
        .local_ip        (local_ip),
        .gateway_ip      (gateway_ip),
        .subnet_mask     (subnet_mask)
    );

    udp_reply_path u_udp_reply_path (
        .clk              (clk),
        .rst              (rst),
        .local_ip         (local_ip),
        .gateway_ip       (gateway_ip),
        .subnet_mask      (subnet_mask),
        .rx_hdr_valid     (rx_hdr_valid),
        .rx_hdr_ready     (rx_hdr_ready),
        .rx_dst_port      (rx_dst_port),
        .rx_src_port      (rx_src_port),
        .rx_src_ip        (rx_src_ip),
        .rx_length        (rx_length),
        .rx_payload_valid (rx_payload_valid),
        .rx_payload_ready (rx_payload_ready),
        .rx_payload_last  (rx_payload_last),
        .rx_payload_user  (rx_payload_user),
        .tx_hdr_valid     (tx_hdr_valid),
        .tx_hdr_ready     (tx_hdr_ready),
        .tx_src_port      (tx_src_port),
        .tx_dst_port      (tx_dst_port),
        .tx_src_ip        (tx_src_ip),
        .tx_dst_ip        (tx_dst_ip),
        .tx_length        (tx_length),
        .tx_ttl           (tx_ttl),
        .fifo_in          (reply_stream.source)
    );

    payload_fifo u_payload_fifo (
        .clk      (clk),
        .rst      (rst),
        .wr       (reply_stream.sink),
        .rd_data  (rd_data),
        .rd_valid (rd_valid),
        .rd_last  (rd_last),
        .rd_user  (rd_user),
        .rd_ready (rd_ready)
    );

endmodule

/* source/udp_reply_path.sv */
`include "responder_settings.svh"

module udp_reply_path (
    input  logic                     clk,
    input  logic                     rst,
    input  responder_pkg::ipv4_addr_u local_ip,
    input  responder_pkg::ipv4_addr_u gateway_ip,
    input  responder_pkg::ipv4_addr_u subnet_mask,

    input  logic                     rx_hdr_valid,
    output logic                     rx_hdr_ready,
    input  responder_pkg::udp_port_t rx_dst_port,
    input  responder_pkg::udp_port_t rx_src_port,
    input  logic [31:0]              rx_src_ip,
    input  logic [15:0]              rx_length,

    input  logic                     rx_payload_valid,
    output logic                     rx_payload_ready,
    input  logic                     rx_payload_last,
    input  logic                     rx_payload_user,

    output logic                     tx_hdr_valid,
    input  logic                     tx_hdr_ready,
    output responder_pkg::udp_port_t tx_src_port,
    output responder_pkg::udp_port_t tx_dst_port,
    output logic [31:0]              tx_src_ip,
    output logic [31:0]              tx_dst_ip,
    output logic [15:0]              tx_length,
    output logic [7:0]               tx_ttl,

    byte_stream_if.source            fifo_in
);

    import responder_pkg::*;

    typedef enum logic [1:0] {MODE_IDLE, MODE_FWD, MODE_DROP} mode_t;

    mode_t       mode;
    logic        port_match;
    logic        hdr_fire;
    logic        last_fire;
    demo_idx_t   ptr;
    demo_table_t demo_table;

    assign port_match = (rx_dst_port == `RESPONDER_PORT);

    // Headers are only taken between frames
    assign tx_hdr_valid = (mode == MODE_IDLE) && rx_hdr_valid && port_match;
    assign rx_hdr_ready = (mode == MODE_IDLE) && (port_match ? tx_hdr_ready : 1'b1);
    assign hdr_fire     = rx_hdr_valid && rx_hdr_ready;

    // Reply header, ports swapped
    assign tx_src_port = rx_dst_port;
    assign tx_dst_port = rx_src_port;
    assign tx_src_ip   = local_ip.word;
    assign tx_dst_ip   = rx_src_ip;
    assign tx_length   = rx_length;
    assign tx_ttl      = `REPLY_TTL;

    assign rx_payload_ready = (mode == MODE_DROP) || (mode == MODE_FWD && fifo_in.tready);
    assign last_fire        = rx_payload_valid && rx_payload_ready && rx_payload_last;

    assign demo_table = {local_ip.octets, gateway_ip.octets, subnet_mask.octets,
                         8'h11, 8'h22, 8'h33, 8'h44};

    assign fifo_in.tvalid = (mode == MODE_FWD) && rx_payload_valid;
    assign fifo_in.tdata  = demo_table[ptr];
    assign fifo_in.tlast  = rx_payload_last;
    assign fifo_in.tuser  = rx_payload_user;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            mode <= MODE_IDLE;
            ptr  <= '0;
        end
        else
        begin
            if (hdr_fire)
                mode <= port_match ? MODE_FWD : MODE_DROP;
            else if (last_fire)
                mode <= MODE_IDLE;

            // Pointer runs on across frames
            if (fifo_in.tvalid && fifo_in.tready)
                ptr <= ptr + 1'b1;
        end
    end

endmodule

/* udp_config_responder.f */
+incdir+common
common/responder_pkg.sv
common/byte_stream_if.sv
flash_config/spi_flash_reader.sv
flash_config/ip_config_loader.sv
source/udp_reply_path.sv
source/payload_fifo.sv
source/udp_config_responder.sv
bench/tb_spi_flash_model.sv
bench/tb_udp_config_responder.sv
